/* list.f */
rtl/frv_pkg.sv
rtl/frv_fetch_buffer.sv
rtl/frv_fetch_pc_track.sv
rtl/frv_pipeline_fetch.sv
rtl/frv_fetch_top.sv
sim/tb_frv_fetch_properties.sv
sim/tb_frv_fetch_checker.sv
sim/tb_frv_fetch.sv

/* rtl/frv_fetch_buffer.sv */
`timescale 1ns/1ps
// Fetch buffer
// Four halfword entries filled from instruction bus words and drained
// from the head as 16-bit compressed or 32-bit instructions

module frv_fetch_buffer import frv_pkg::*; (
    input  logic      g_clk,      // Global clock
    input  logic      g_resetn,   // Synchronous active low reset
    input  logic      flush,      // Drop everything held
    input  logic      f_4byte,    // Load a whole word
    input  logic      f_2byte,    // Load the upper halfword only
    input  logic      f_err,      // Bus error on this word
    input  frv_word_t f_in,       // Word from the bus
    output logic      f_ready,    // Room for a whole word
    output frv_word_t buf_out,    // Instruction at the head
    output frv_len_t  buf_len,    // Its length
    output logic      buf_err,    // Some part came with an error
    output logic      buf_valid,  // Head instruction complete
    input  logic      buf_ready   // Consume the head instruction
);

logic [15:0] hw_q    [4];         // Halfword entries with 0 at the head
logic        err_q   [4];         // Error bit per entry
logic [15:0] hw_nxt  [4];
logic        err_nxt [4];
logic [15:0] in_hw   [2];         // Incoming halfwords in address order
logic [2:0]  cnt_q;               // Entries in use
logic [2:0]  cnt_shift;           // Entries left after the drain
logic [2:0]  cnt_nxt;
logic [2:0]  slot;                // Incoming halfword index for an entry
logic [1:0]  n_eat;               // Halfwords drained this cycle
logic [1:0]  n_in;                // Halfwords loaded this cycle
logic        head_4;              // Head is a 32-bit instruction
logic        eat;

// --------------------------------------------------
// Head decode

assign head_4    = (hw_q[0][1:0] == 2'b11);                 // Low bits 11 mean 32-bit
assign buf_len   = head_4 ? LEN_4 : LEN_2;
assign buf_valid = head_4 ? (cnt_q >= 3'd2) : (cnt_q >= 3'd1); // Need both halves
assign buf_out   = head_4 ? {hw_q[1], hw_q[0]} : {16'h0000, hw_q[0]};
assign buf_err   = err_q[0] || (head_4 && err_q[1]);
assign f_ready   = (cnt_q <= 3'd2);                         // Two free entries

// --------------------------------------------------
// Drain and fill

assign eat   = buf_valid && buf_ready;
assign n_eat = !eat ? 2'd0 : (head_4 ? 2'd2 : 2'd1);
assign n_in  = f_4byte ? 2'd2 : (f_2byte ? 2'd1 : 2'd0);

assign in_hw[0] = f_2byte ? f_in[31:16] : f_in[15:0];       // Upper half only if misaligned
assign in_hw[1] = f_in[31:16];

assign cnt_shift = cnt_q - {1'b0, n_eat};
assign cnt_nxt   = cnt_shift + {1'b0, n_in};

// Shift survivors down then append new halfwords behind them
always_comb begin
    hw_nxt  = hw_q;
    err_nxt = err_q;
    slot    = 3'd0;
    for (int i = 0; i < 4; i++) begin
        if (3'(i) < cnt_shift) begin
            hw_nxt[i]  = hw_q[2'(i + int'(n_eat))];   // Kept entry moves down
            err_nxt[i] = err_q[2'(i + int'(n_eat))];
        end else begin
            slot = 3'(i) - cnt_shift;
            if (slot < {1'b0, n_in}) begin
                hw_nxt[i]  = in_hw[slot[0]];           // Fresh halfword
                err_nxt[i] = f_err;
            end
        end
    end
end

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        cnt_q <= 3'd0;
    end else if (flush) begin
        cnt_q <= 3'd0;                                 // Flush beats any load
    end else begin
        cnt_q <= cnt_nxt;
    end
end

// Entries only matter below cnt_q
always_ff @(posedge g_clk) begin
    hw_q  <= hw_nxt;
    err_q <= err_nxt;
end

endmodule

/* rtl/frv_fetch_pc_track.sv */
`timescale 1ns/1ps
// Fetch PC tracker
// Holds the address of the instruction at the fetch buffer head

module frv_fetch_pc_track import frv_pkg::*; (
    input  logic     g_clk,      // Global clock
    input  logic     g_resetn,   // Synchronous active low reset
    input  logic     load,       // Control flow change taken
    input  frv_pc_t  load_pc,    // Exact target with halfword accuracy
    input  logic     advance,    // Head instruction consumed
    input  frv_len_t len,        // Length of the consumed instruction
    output frv_pc_t  pc          // Address of the head instruction
);

frv_pc_t pc_step;

assign pc_step = (len == LEN_4) ? 32'd4 : 32'd2;

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        pc <= FRV_PC_RESET_VALUE;
    end else if (load) begin
        pc <= load_pc;           // Redirect wins over consume
    end else if (advance) begin
        pc <= pc + pc_step;
    end
end

endmodule

/* rtl/frv_fetch_top.sv */
`timescale 1ns/1ps
// Fetch stage top level
// Brings the fetch stage out to the instruction bus and decode pins

module frv_fetch_top import frv_pkg::*; (
    input  logic      g_clk,       // Global clock
    input  logic      g_resetn,    // Synchronous active low reset
    input  logic      cf_req,      // Control flow change
    input  frv_pc_t   cf_target,
    output logic      cf_ack,
    output logic      imem_req,    // Instruction bus request phase
    output frv_pc_t   imem_addr,
    input  logic      imem_gnt,
    output logic      imem_ack,    // Instruction bus response phase
    input  logic      imem_recv,
    input  logic      imem_error,
    input  frv_word_t imem_rdata,
    input  logic      fe_stall,    // Decode side
    output logic      fe_ready,
    output frv_word_t d_data,
    output frv_len_t  d_len,
    output frv_pc_t   d_pc,
    output logic      d_error
);

frv_pipeline_fetch i_pipeline_fetch (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .cf_req     (cf_req),
    .cf_target  (cf_target),
    .cf_ack     (cf_ack),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_gnt   (imem_gnt),
    .imem_ack   (imem_ack),
    .imem_recv  (imem_recv),
    .imem_error (imem_error),
    .imem_rdata (imem_rdata),
    .fe_stall   (fe_stall),
    .fe_ready   (fe_ready),
    .d_data     (d_data),
    .d_len      (d_len),
    .d_pc       (d_pc),
    .d_error    (d_error)
);

endmodule

/* rtl/frv_pipeline_fetch.sv */
`timescale 1ns/1ps
// Fetch pipeline stage
// Issues word reads on the instruction bus with up to two in flight
// Drops responses made stale by a control flow change and feeds decode

module frv_pipeline_fetch import frv_pkg::*; (
    input  logic      g_clk,       // Global clock
    input  logic      g_resetn,    // Synchronous active low reset
    input  logic      cf_req,      // Control flow change
    input  frv_pc_t   cf_target,   // Its target
    output logic      cf_ack,      // Change accepted
    output logic      imem_req,    // Start memory request
    output frv_pc_t   imem_addr,   // Word aligned read address
    input  logic      imem_gnt,    // Request accepted
    output logic      imem_ack,    // Response accepted
    input  logic      imem_recv,   // Response present
    input  logic      imem_error,  // Response error
    input  frv_word_t imem_rdata,  // Read data
    input  logic      fe_stall,    // Decode holds the head
    output logic      fe_ready,    // Whole instruction available
    output frv_word_t d_data,      // Instruction
    output frv_len_t  d_len,       // Its length
    output frv_pc_t   d_pc,        // Its address
    output logic      d_error      // Fetched with an error
);

logic     f_ready;                 // Buffer has room for a word
logic     f_4byte;
logic     f_2byte;
logic     buf_valid;
logic     buf_ready;
logic     cf_change;               // Change taken this cycle
logic     req_grant;
logic     rsp_recv;                // Response handshake
logic     rsp_valid;               // Response kept for the buffer
logic     n_imem_req;
logic     fetch_misaligned;        // Next kept word loads its upper half only
frv_cnt_t reqs_out_q;              // Granted requests awaiting response
frv_cnt_t n_reqs_out;
frv_cnt_t stale_q;                 // Of those the ones to drop

// --------------------------------------------------
// Pipeline progression

assign fe_ready  = buf_valid;
assign buf_ready = buf_valid && !fe_stall;

assign cf_ack    = !imem_req || imem_gnt;          // No request left hanging
assign cf_change = cf_req && cf_ack;

// --------------------------------------------------
// Memory bus requests

assign req_grant  = imem_req && imem_gnt;
assign n_reqs_out = reqs_out_q + frv_cnt_t'(req_grant) - frv_cnt_t'(rsp_recv);

// Hold an ungranted request and otherwise issue while under the limit
assign n_imem_req = (imem_req && !imem_gnt) ||
                    ((f_ready || cf_change) && (n_reqs_out < FRV_MAX_OUTSTANDING));

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        imem_req <= 1'b0;
    end else begin
        imem_req <= n_imem_req;
    end
end

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        imem_addr <= FRV_PC_RESET_VALUE;
    end else if (cf_change) begin
        imem_addr <= {cf_target[31:2], 2'b00};     // Round down to a word
    end else if (req_grant) begin
        imem_addr <= imem_addr + 32'd4;
    end
end

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        reqs_out_q <= '0;
    end else begin
        reqs_out_q <= n_reqs_out;
    end
end

// --------------------------------------------------
// Stale responses and misalignment

// Everything in flight at a change is stale
always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        stale_q <= '0;
    end else if (cf_change) begin
        stale_q <= n_reqs_out;
    end else if (rsp_recv && (stale_q != '0)) begin
        stale_q <= stale_q - frv_cnt_t'(1);
    end
end

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        fetch_misaligned <= 1'b0;
    end else if (cf_change) begin
        fetch_misaligned <= cf_target[1];          // Halfword target
    end else if (rsp_valid) begin
        fetch_misaligned <= 1'b0;                  // Only the first word
    end
end

// --------------------------------------------------
// Memory bus responses

assign imem_ack  = f_ready || (stale_q != '0);     // Drain stale ones regardless
assign rsp_recv  = imem_recv && imem_ack;
assign rsp_valid = rsp_recv && (stale_q == '0) && !cf_change;

assign f_4byte = rsp_valid && !fetch_misaligned;
assign f_2byte = rsp_valid &&  fetch_misaligned;

// --------------------------------------------------
// Submodules

frv_fetch_buffer i_fetch_buffer (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .flush     (cf_change),
    .f_4byte   (f_4byte),
    .f_2byte   (f_2byte),
    .f_err     (imem_error),
    .f_in      (imem_rdata),
    .f_ready   (f_ready),
    .buf_out   (d_data),
    .buf_len   (d_len),
    .buf_err   (d_error),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready)
);

frv_fetch_pc_track i_fetch_pc_track (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .load     (cf_change),
    .load_pc  (cf_target),
    .advance  (buf_ready),
    .len      (d_len),
    .pc       (d_pc)
);

endmodule

/* rtl/frv_pkg.sv */
// Shared definitions for the instruction fetch stage
// Bus word and address types, instruction length and fetch limits

package frv_pkg;

// --------------------------------------------------
// Types

typedef logic [31:0] frv_word_t;   // Instruction bus data word
typedef logic [31:0] frv_pc_t;     // Byte address

// Length of the instruction at the buffer head
typedef enum logic {
    LEN_2 = 1'b0,                  // Compressed 16-bit
    LEN_4 = 1'b1                   // Full 32-bit
} frv_len_t;

typedef logic [1:0] frv_cnt_t;     // Outstanding and stale response counts

// --------------------------------------------------
// Constants

localparam frv_pc_t  FRV_PC_RESET_VALUE  = 32'h8000_0000; // First fetch address
localparam frv_cnt_t FRV_MAX_OUTSTANDING = 2'd2;          // Requests in flight

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_frv_fetch -Mdir obj_dir \
    -f list.f > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_frv_fetch +verilator+error+limit+1000 > sim.log 2>&1
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* sim/fetch_vectors.hex */
// Entries 0-63: memory image from 0x80000000, top digit 1 marks a bus error word
// Entry 64: instructions to consume, 65: redirect count, then pairs of count and target
0_00000297 0_02028293 1_45014185 0_00a50513
0_80824501 0_05130041 0_00000100 0_fe0718e3
0_00112623 0_c0061141 0_47854501 0_0007a783
0_00f50733 0_87aa8082 0_00b7e463 0_0ff00793
0_4681c305 0_00d72023 0_0685c398 0_fed61ce3
0_01c12083 1_35138082 0_00000011 0_41018522
0_01010113 0_e4064711 0_00a12423 0_0513c22e
0_4581fff0 0_00000317 0_000300e7 0_85aa46a1
0_00052503 0_fff6c693 0_0017f713 0_8f0dc699
0_40e78733 0_00e7a023 0_84aa0505 0_00000073
0_00100073 1_c0211101 0_02b50633 0_8e6d0f93
0_0206d463 0_4701557d 0_00e51863 0_00179713
0_30200073 0_8d894d05 0_10500073 0_00c10513
0_00f6f693 0_79fd0785 1_fe069ae3 0_4a01c232
0_00008067 0_00e6a223 0_54fd4505 0_0006c703
0_02d75863 0_0297852e 0_00d7e5b3 0_0000006f
0_00000038 0_00000004
0_0000000c 0_800000a0 0_00000018 0_80000052
0_00000024 0_80000016 0_00000030 0_800000c8

/* sim/tb_frv_fetch.sv */
`timescale 1ns/1ps
// Fetch stage testbench
// Random bus timing and decode stalls around the fetch stage
// Memory image and redirects come from the vector file

module tb_frv_fetch import frv_pkg::*; ();

logic        g_clk;
logic        g_resetn;
logic        cf_req;
frv_pc_t     cf_target;
logic        cf_ack;
logic        imem_req;
frv_pc_t     imem_addr;
logic        imem_gnt;
logic        imem_ack;
logic        imem_recv;
logic        imem_error;
frv_word_t   imem_rdata;
logic        fe_stall;
logic        fe_ready;
frv_word_t   d_data;
frv_len_t    d_len;
frv_pc_t     d_pc;
logic        d_error;

logic [35:0] vec [0:79];            // Raw vector file
logic [35:0] image [64];            // {error nibble, word} from the reset PC
int          redir_count [8];       // Consumed count that triggers a redirect
frv_pc_t     redir_target [8];
int          redir_total;
int          end_count;             // Instructions to consume in total
int          redir_idx;
int          consumed;
int          checked;
int          mismatches;
int          model_errors;
int          cf_wait;               // Cycles cf_req has waited for cf_ack
logic        rsp_taken;
logic [32:0] rsp_q [$];             // Responses in flight {error, data}
logic [31:0] lfsr_q = 32'h078badd4;

frv_fetch_top DUT (.*);

tb_frv_fetch_checker fetch_checker (.*);

// --------------------------------------------------
// Random source and memory contents

// Galois LFSR, one step per bit
function automatic logic [3:0] random_bits(input int n);
    logic [3:0] bits;
    bits = 4'd0;
    for (int i = 0; i < n; i++) begin
        bits   = {bits[2:0], lfsr_q[0]};
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return bits;
endfunction

function automatic logic [32:0] mem_read(input frv_pc_t addr);
    frv_pc_t offs;
    offs = addr - FRV_PC_RESET_VALUE;
    if (offs < 32'd256) begin
        return {image[offs[7:2]][32], image[offs[7:2]][31:0]};
    end
    return {1'b0, addr ^ 32'h5a5a_a5a5};          // Outside the image
endfunction

initial begin
    g_clk = 1'b0;
    forever #4 g_clk = ~g_clk;
end

// --------------------------------------------------
// Memory model, decode stalls and redirects

always @(posedge g_clk) begin
    if (!g_resetn) begin
        imem_gnt     <= 1'b0;
        imem_recv    <= 1'b0;
        fe_stall     <= 1'b0;
        cf_req       <= 1'b0;
        rsp_q.delete();
        consumed     = 0;
        redir_idx    = 0;
        cf_wait      = 0;
        model_errors = 0;
    end else begin
        if (fe_ready && !fe_stall) consumed++;
        fe_stall <= (random_bits(2) == 4'd0);          // Stall one cycle in four
        if (cf_req && cf_ack) begin
            cf_req  <= 1'b0;
            redir_idx++;
            cf_wait = 0;
        end else if (cf_req) begin
            cf_wait++;
            if (cf_wait == 200) begin
                $display("Control flow change not accepted within 200 cycles");
                model_errors++;
            end
        end else if (redir_idx < redir_total && consumed >= redir_count[redir_idx]) begin
            cf_req    <= 1'b1;
            cf_target <= redir_target[redir_idx];
        end
        rsp_taken = imem_recv && imem_ack;
        if (rsp_taken) void'(rsp_q.pop_front());
        if (imem_req && imem_gnt) rsp_q.push_back(mem_read(imem_addr));
        imem_gnt <= (random_bits(2) != 4'd0);
        if (!imem_recv || rsp_taken) begin             // Held until acknowledged
            if (rsp_q.size() != 0 && random_bits(2) != 4'd0) begin
                imem_recv  <= 1'b1;
                imem_rdata <= rsp_q[0][31:0];
                imem_error <= rsp_q[0][32];
            end else begin
                imem_recv  <= 1'b0;
            end
        end
    end
end

// --------------------------------------------------
// Setup, reset and end of run

initial begin : main
    int wait_cycles;
    int failures;
    g_resetn   <= 1'b0;
    cf_req     <= 1'b0;
    cf_target  <= FRV_PC_RESET_VALUE;
    imem_gnt   <= 1'b0;
    imem_recv  <= 1'b0;
    imem_error <= 1'b0;
    imem_rdata <= 32'h0000_0000;
    fe_stall   <= 1'b0;
    $readmemh("sim/fetch_vectors.hex", vec);
    for (int i = 0; i < 64; i++) image[i] = vec[i];
    end_count   = int'(vec[64][31:0]);
    redir_total = int'(vec[65][31:0]);
    for (int i = 0; i < redir_total && i < 8; i++) begin
        redir_count[i]  = int'(vec[66 + 2 * i][31:0]);
        redir_target[i] = vec[67 + 2 * i][31:0];
    end
    repeat (8) @(posedge g_clk);
    g_resetn <= 1'b1;
    wait_cycles = 0;
    while (consumed < end_count && wait_cycles < 20000) begin
        @(negedge g_clk);
        wait_cycles++;
    end
    if (consumed < end_count) begin
        $display("Timed out with %0d of %0d instructions consumed", consumed, end_count);
    end
    failures = mismatches + model_errors + DUT.i_pipeline_fetch.fetch_props.fail_count;
    $display("Checked %0d instructions: %0d mismatches, %0d model errors, %0d assertion failures",
             checked, mismatches, model_errors, DUT.i_pipeline_fetch.fetch_props.fail_count);
    if (consumed >= end_count && failures == 0) begin
        $display("Simulation passed");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

/* sim/tb_frv_fetch_checker.sv */
`timescale 1ns/1ps
// Fetch stage checker
// Walks the memory image from the expected PC to predict each consumed
// instruction and compares it with the decode outputs

module tb_frv_fetch_checker import frv_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic [35:0] image [64],  // {error nibble, word} per word
    input  logic        cf_req,
    input  logic        cf_ack,
    input  frv_pc_t     cf_target,
    input  logic        fe_ready,
    input  logic        fe_stall,
    input  frv_word_t   d_data,
    input  frv_len_t    d_len,
    input  frv_pc_t     d_pc,
    input  logic        d_error,
    output int          checked,
    output int          mismatches
);

frv_pc_t     exp_pc;                 // Walk position
logic [35:0] lo_entry;               // Word holding the first halfword
logic [35:0] hi_entry;               // Word holding the second halfword
logic [15:0] lo_hw;
logic [15:0] hi_hw;
logic        exp_len4;

function automatic logic [35:0] entry_at(input frv_pc_t addr);
    frv_pc_t offs;
    offs = addr - FRV_PC_RESET_VALUE;
    return image[offs[7:2]];
endfunction

task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %s = 0x%08h, expected 0x%08h (instruction %0d)",
                 name, got, exp, checked);
        mismatches++;
    end
endtask

always @(posedge g_clk) begin
    if (!g_resetn) begin
        exp_pc     = FRV_PC_RESET_VALUE;
        checked    = 0;
        mismatches = 0;
    end else begin
        if (fe_ready && !fe_stall) begin
            if ((exp_pc - FRV_PC_RESET_VALUE) >= 32'd254) begin
                $display("Expected PC 0x%08h lies outside the memory image", exp_pc);
                mismatches++;
            end
            lo_entry = entry_at(exp_pc);
            hi_entry = entry_at(exp_pc + 32'd2);
            lo_hw    = exp_pc[1] ? lo_entry[31:16] : lo_entry[15:0];
            hi_hw    = exp_pc[1] ? hi_entry[15:0] : hi_entry[31:16];
            exp_len4 = (lo_hw[1:0] == 2'b11);    // Low bits 11 mean 32-bit
            compare_value("d_pc", d_pc, exp_pc);
            compare_value("d_len", {31'd0, d_len}, {31'd0, exp_len4});
            compare_value("d_data", d_data, exp_len4 ? {hi_hw, lo_hw} : {16'h0000, lo_hw});
            compare_value("d_error", {31'd0, d_error},
                          {31'd0, lo_entry[32] || (exp_len4 && hi_entry[32])});
            exp_pc  = exp_pc + (exp_len4 ? 32'd4 : 32'd2);
            checked++;
        end
        if (cf_req && cf_ack) exp_pc = cf_target;  // Walk restarts at the target
    end
end

endmodule

/* sim/tb_frv_fetch_properties.sv */
`timescale 1ns/1ps
// Fetch stage handshake assertions
// Bound into the fetch pipeline stage

module tb_frv_fetch_properties import frv_pkg::*; (
    input logic    g_clk,
    input logic    g_resetn,
    input logic    imem_req,
    input logic    imem_gnt,
    input frv_pc_t imem_addr,
    input logic    imem_recv,
    input logic    imem_ack,
    input logic    cf_req,
    input logic    cf_ack,
    input logic    fe_ready
);

int in_flight;                       // Granted requests without a response
int fail_count = 0;

always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        in_flight <= 0;
    end else begin
        in_flight <= in_flight + int'(imem_req && imem_gnt) - int'(imem_recv && imem_ack);
    end
end

a_outstanding: assert property (@(posedge g_clk) disable iff (!g_resetn)
    in_flight >= 0 && in_flight <= int'(FRV_MAX_OUTSTANDING))
    else begin
        fail_count++;
        $error("More than two requests outstanding");
    end

a_addr_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
    imem_req && !imem_gnt |=> imem_req && $stable(imem_addr))
    else begin
        fail_count++;
        $error("Request or address changed before grant");
    end

// A taken change empties the buffer so nothing is offered next cycle
a_cf_flush: assert property (@(posedge g_clk) disable iff (!g_resetn)
    cf_req && cf_ack |=> !fe_ready)
    else begin
        fail_count++;
        $error("Buffer not flushed by a control flow change");
    end

endmodule

bind frv_pipeline_fetch tb_frv_fetch_properties fetch_props (
    .g_clk     (g_clk),
    .g_resetn  (g_resetn),
    .imem_req  (imem_req),
    .imem_gnt  (imem_gnt),
    .imem_addr (imem_addr),
    .imem_recv (imem_recv),
    .imem_ack  (imem_ack),
    .cf_req    (cf_req),
    .cf_ack    (cf_ack),
    .fe_ready  (fe_ready)
);
